//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic MCLK,
    output logic rst_n
);

    initial
    begin
        MCLK = 1'b0;
        forever #(PERIOD_NS / 2) MCLK = ~MCLK;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge MCLK);
        #1 rst_n = 1'b1;  // released just after an edge
    end

endmodule

//--- bench/tb_tempsense.sv
`timescale 1ns/1ps

module tb_tempsense;

    localparam int CLKS_PER_SEC    = 20;
    localparam int SCK_DIV         = 2;
    localparam int CHECK_PERIOD_S  = 3;
    localparam int READ_CYCLES     = 32 * SCK_DIV + 3;
    localparam int MEAS_LIMIT      = 2 * (CLKS_PER_SEC + READ_CYCLES) + 20;
    localparam int FAN_LIMIT       = (CHECK_PERIOD_S + 2) * CLKS_PER_SEC + READ_CYCLES + 20;
    localparam int WATCHDOG_CYCLES = 150_000;

    localparam int SIG_HOLD  = 0;
    localparam int SIG_DELAY = 1;
    localparam int SIG_FAN   = 2;
    localparam int SIG_CS    = 3;

    logic        MCLK;
    logic        rst_n;
    logic        en;
    logic [2:0]  setting;
    logic        force_start;
    logic        hold_boot;
    logic        delaying;
    logic        fan_on;
    logic        sensor_cs;
    logic        sensor_sck;
    logic        sensor_sio;
    logic [12:0] sensor_temp;
    logic        sensor_complete;
    int          read_count;

    int          errors   = 0;
    int          timeouts = 0;
    int          checks   = 0;
    logic [31:0] rng      = 32'd99;

    clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) clk_gen_i (.MCLK(MCLK), .rst_n(rst_n));

    tc77_model tc77_model_i (
        .MCLK       (MCLK),
        .sensor_cs  (sensor_cs),
        .sensor_sck (sensor_sck),
        .sensor_sio (sensor_sio),
        .temp_raw   (sensor_temp),
        .complete   (sensor_complete),
        .read_count (read_count)
    );

    drive_tempsense_top #(
        .CLKS_PER_SEC   (CLKS_PER_SEC),
        .SCK_DIV        (SCK_DIV),
        .CHECK_PERIOD_S (CHECK_PERIOD_S)
    ) dut_i (
        .MCLK        (MCLK),
        .rst_n       (rst_n),
        .en          (en),
        .setting     (setting),
        .force_start (force_start),
        .hold_boot   (hold_boot),
        .delaying    (delaying),
        .fan_on      (fan_on),
        .sensor_cs   (sensor_cs),
        .sensor_sck  (sensor_sck),
        .sensor_sio  (sensor_sio)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 485 - 16.8 * T with T = raw / 16, fraction dropped
    function automatic int expected_delay(input int raw);
        return (48500 - 105 * raw) / 100;
    endfunction

    function automatic logic probe(input int which);
        case (which)
            SIG_HOLD:  return hold_boot;
            SIG_DELAY: return delaying;
            SIG_FAN:   return fan_on;
            default:   return sensor_cs;
        endcase
    endfunction

    function automatic string probe_name(input int which);
        case (which)
            SIG_HOLD:  return "hold_boot";
            SIG_DELAY: return "delaying";
            SIG_FAN:   return "fan_on";
            default:   return "sensor_cs";
        endcase
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_seconds(input string name, input timing_pkg::seconds_t got,
                                 input timing_pkg::seconds_t exp, input int tol);
        int diff;
        diff = int'(got) - int'(exp);
        checks++;
        if (diff > tol || diff < -tol)
        begin
            errors++;
            $display("[ERROR] %0d ns %s: got %0d s, expected %0d s", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge MCLK);
        #1;  // drive and sample away from the edge
    endtask

    task automatic wait_level(input int which, input logic level, input int limit,
                              output int cycles);
        cycles = 0;
        while (probe(which) !== level && cycles < limit)
        begin
            next_cycle();
            cycles++;
        end
        if (probe(which) !== level)
        begin
            timeouts++;
            $display("timeout at %0d ns: %s did not go to %b within %0d cycles",
                     $time, probe_name(which), level, limit);
        end
    endtask

    task automatic disable_dut();
        int cycles;
        en          = 1'b0;
        force_start = 1'b0;
        repeat (4) next_cycle();
        wait_level(SIG_CS, 1'b1, READ_CYCLES + 10, cycles);  // let an open read finish
        wait_level(SIG_HOLD, 1'b1, 10, cycles);
    endtask

    task automatic test_reset_state();
        repeat (30)
        begin
            check_bit("hold_boot", hold_boot, 1'b1);
            check_bit("delaying", delaying, 1'b0);
            check_bit("fan_on", fan_on, 1'b0);
            check_bit("sensor_cs", sensor_cs, 1'b1);
            check_bit("sensor_sck", sensor_sck, 1'b0);
            next_cycle();
        end
    endtask

    task automatic test_fixed_mode(input timing_pkg::delay_mode_t mode, input int exp_s);
        int cycles;
        int base;
        disable_dut();
        base    = read_count;
        setting = {1'b0, mode};
        en      = 1'b1;
        wait_level(SIG_DELAY, 1'b1, 6, cycles);
        wait_level(SIG_HOLD, 1'b0, (exp_s + 2) * CLKS_PER_SEC, cycles);
        check_seconds("fixed delay", timing_pkg::seconds_t'(cycles / CLKS_PER_SEC),
                      timing_pkg::seconds_t'(exp_s), 1);
        check_bit("delaying", delaying, 1'b0);
        check_count("sensor reads", read_count - base, 0);
    endtask

    task automatic test_measured(input int raw, input bit incomplete_first, input int exp_reads);
        int cycles;
        int base;
        int exp_s;
        disable_dut();
        base            = read_count;
        sensor_temp     = 13'(raw);
        sensor_complete = !incomplete_first;
        setting         = 3'b011;
        en              = 1'b1;
        if (incomplete_first)
        begin
            cycles = 0;
            while (read_count == base && cycles < MEAS_LIMIT)
            begin
                next_cycle();
                cycles++;
            end
            if (read_count == base)
            begin
                timeouts++;
                $display("timeout at %0d ns: no first sensor read", $time);
            end
            sensor_complete = 1'b1;  // second read is complete
        end
        wait_level(SIG_DELAY, 1'b1, MEAS_LIMIT, cycles);
        check_count("sensor reads", read_count - base, exp_reads);
        exp_s = expected_delay(raw);
        wait_level(SIG_HOLD, 1'b0, (exp_s + 2) * CLKS_PER_SEC, cycles);
        check_seconds("measured delay", timing_pkg::seconds_t'(cycles / CLKS_PER_SEC),
                      timing_pkg::seconds_t'(exp_s), 1);
        if (raw < 0)
            check_bit("delay above 485 s", (cycles / CLKS_PER_SEC) > 485, 1'b1);
    endtask

    task automatic test_measured_hot(input int raw);
        int   cycles;
        int   base;
        logic saw_delay;
        disable_dut();
        base            = read_count;
        saw_delay       = 1'b0;
        sensor_temp     = 13'(raw);
        sensor_complete = 1'b1;
        setting         = 3'b011;
        en              = 1'b1;
        cycles          = 0;
        while (hold_boot !== 1'b0 && cycles < MEAS_LIMIT)
        begin
            next_cycle();
            cycles++;
            if (delaying)
                saw_delay = 1'b1;
        end
        if (hold_boot !== 1'b0)
        begin
            timeouts++;
            $display("timeout at %0d ns: warm reading did not release the boot", $time);
        end
        check_bit("delaying", saw_delay, 1'b0);
        check_count("sensor reads", read_count - base, 1);
    endtask

    task automatic test_force(input timing_pkg::delay_mode_t mode, input bit after_delaying);
        int cycles;
        disable_dut();
        sensor_temp     = 13'd0;  // 485 s in measured mode
        sensor_complete = 1'b1;
        setting         = {1'b0, mode};
        en              = 1'b1;
        if (after_delaying)
            wait_level(SIG_DELAY, 1'b1, (mode == timing_pkg::MODE_MEASURED) ? MEAS_LIMIT : 6,
                       cycles);
        repeat (10) next_cycle();
        force_start = 1'b1;
        wait_level(SIG_HOLD, 1'b0, 6, cycles);
        force_start = 1'b0;
        check_bit("hold_boot", hold_boot, 1'b0);
    endtask

    task automatic test_fan_on_off();
        int cycles;
        int base;
        disable_dut();
        base            = read_count;
        sensor_temp     = 13'd640;  // 40 degC
        sensor_complete = 1'b1;
        setting         = 3'b100;
        en              = 1'b1;
        wait_level(SIG_HOLD, 1'b0, 4 * CLKS_PER_SEC, cycles);
        wait_level(SIG_FAN, 1'b1, FAN_LIMIT, cycles);
        check_bit("fan_on", fan_on, 1'b1);
        check_count("sensor reads", read_count - base, 1);
        sensor_temp = 13'd608;  // exactly 38 degC
        wait_level(SIG_FAN, 1'b0, FAN_LIMIT, cycles);
        check_bit("fan_on", fan_on, 1'b0);
        check_seconds("fan check period", timing_pkg::seconds_t'(cycles / CLKS_PER_SEC),
                      timing_pkg::seconds_t'(CHECK_PERIOD_S + 1), 0);
        check_count("sensor reads", read_count - base, 2);
        check_bit("hold_boot", hold_boot, 1'b0);
    endtask

    task automatic test_fan_disabled();
        int   cycles;
        int   base;
        logic saw_fan;
        disable_dut();
        base        = read_count;
        saw_fan     = 1'b0;
        sensor_temp = 13'd640;
        setting     = 3'b000;
        en          = 1'b1;
        wait_level(SIG_HOLD, 1'b0, 4 * CLKS_PER_SEC, cycles);
        repeat (2 * FAN_LIMIT)
        begin
            next_cycle();
            if (fan_on)
                saw_fan = 1'b1;
        end
        check_bit("fan_on", saw_fan, 1'b0);
        check_count("sensor reads", read_count - base, 0);
    endtask

    initial
    begin
        int raw;
        int cycles;
        en              = 1'b0;
        setting         = 3'b000;
        force_start     = 1'b0;
        sensor_temp     = 13'd0;
        sensor_complete = 1'b1;
        cycles          = 0;
        while (rst_n !== 1'b1 && cycles < 10)
        begin
            next_cycle();
            cycles++;
        end
        if (rst_n !== 1'b1)
        begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        test_reset_state();
        test_fixed_mode(timing_pkg::MODE_SHORT, 2);
        test_fixed_mode(timing_pkg::MODE_MID, 80);
        test_fixed_mode(timing_pkg::MODE_LONG, 260);

        rng = xorshift32(rng);
        raw = int'(rng % 32'd417);  // 0 to 26 degC
        test_measured(raw, 1'b1, 2);
        rng = xorshift32(rng);
        raw = int'(rng % 32'd417);
        test_measured(raw, 1'b0, 1);
        test_measured_hot(480);          // 30 degC
        test_measured(-160, 1'b0, 2);    // -10 degC, read twice

        test_force(timing_pkg::MODE_LONG, 1'b1);
        test_force(timing_pkg::MODE_MEASURED, 1'b1);
        test_force(timing_pkg::MODE_MEASURED, 1'b0);  // before the first read
        test_fan_on_off();
        test_fan_disabled();

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge MCLK);
        $display("simulation ran past its cycle limit without finishing");
        $display("tests failed");
        $finish;
    end

endmodule

//--- bench/tc77_model.sv
`timescale 1ns/1ps

// TC77 serial model, 16-bit frame msb first
//   [15:3] temperature, [2] complete, [1:0] high
module tc77_model (
    input  logic        MCLK,
    input  logic        sensor_cs,
    input  logic        sensor_sck,
    output logic        sensor_sio,
    input  logic [12:0] temp_raw,
    input  logic        complete,
    output int          read_count
);

    logic [15:0] frame = '0;
    logic        cs_d  = 1'b1;
    logic        sck_d = 1'b0;
    int          count = 0;

    assign sensor_sio = frame[15];
    assign read_count = count;

    // edges are seen mid cycle, away from the reader's sampling edge
    always @(negedge MCLK)
    begin
        if (cs_d && !sensor_cs)
        begin
            frame <= {temp_raw, complete, 2'b11};  // word fixed for the whole read
            count <= count + 1;
        end
        else if (!sensor_cs && sck_d && !sensor_sck)
        begin
            frame <= {frame[14:0], 1'b1};  // next bit after each falling sck
        end
        cs_d  <= sensor_cs;
        sck_d <= sensor_sck;
    end

endmodule

//--- list.f
src/sensor_pkg.sv
src/timing_pkg.sv
src/second_timer.sv
src/tc77_reader.sv
src/switch_regs.sv
src/startup_ctrl.sv
src/drive_tempsense_top.sv
bench/clk_gen.sv
bench/tc77_model.sv
bench/tb_tempsense.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_tempsense \
    -Mdir obj_dir -o tb_tempsense_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_tempsense_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0

//--- src/drive_tempsense_top.sv
`timescale 1ns/1ps

module drive_tempsense_top #(
    parameter int CLKS_PER_SEC   = 50_000_000,
    parameter int SCK_DIV        = 25,
    parameter int CHECK_PERIOD_S = 20
) (
    input  logic       MCLK,
    input  logic       rst_n,
    input  logic       en,
    input  logic [2:0] setting,
    input  logic       force_start,
    output logic       hold_boot,
    output logic       delaying,
    output logic       fan_on,
    output logic       sensor_cs,
    output logic       sensor_sck,
    input  logic       sensor_sio
);

    logic                    en_sync;
    timing_pkg::delay_mode_t delay_mode;
    logic                    fan_enable;
    logic                    force_pulse;
    logic                    timer_clear;
    logic                    timer_run;
    timing_pkg::seconds_t    elapsed;
    logic                    temp_load;
    logic                    temp_done;
    sensor_pkg::tc77_word_t  temp_word;

    switch_regs switch_regs_i (
        .MCLK        (MCLK),
        .rst_n       (rst_n),
        .en          (en),
        .setting     (setting),
        .force_start (force_start),
        .en_sync     (en_sync),
        .delay_mode  (delay_mode),
        .fan_enable  (fan_enable),
        .force_pulse (force_pulse)
    );

    startup_ctrl #(
        .CHECK_PERIOD_S (CHECK_PERIOD_S)
    ) startup_ctrl_i (
        .MCLK        (MCLK),
        .rst_n       (rst_n),
        .en_sync     (en_sync),
        .delay_mode  (delay_mode),
        .fan_enable  (fan_enable),
        .force_pulse (force_pulse),
        .timer_clear (timer_clear),
        .timer_run   (timer_run),
        .elapsed     (elapsed),
        .temp_load   (temp_load),
        .temp_done   (temp_done),
        .temp_word   (temp_word),
        .hold_boot   (hold_boot),
        .delaying    (delaying),
        .fan_on      (fan_on)
    );

    second_timer #(
        .CLKS_PER_SEC (CLKS_PER_SEC)
    ) second_timer_i (
        .MCLK    (MCLK),
        .rst_n   (rst_n),
        .clear   (timer_clear),
        .run     (timer_run),
        .elapsed (elapsed)
    );

    tc77_reader #(
        .SCK_DIV (SCK_DIV)
    ) tc77_reader_i (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .load       (temp_load),
        .done       (temp_done),
        .temp_word  (temp_word),
        .sensor_cs  (sensor_cs),
        .sensor_sck (sensor_sck),
        .sensor_sio (sensor_sio)
    );

endmodule

//--- src/second_timer.sv
`timescale 1ns/1ps

module second_timer #(
    parameter int CLKS_PER_SEC = 50_000_000
) (
    input  logic                 MCLK,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 run,
    output timing_pkg::seconds_t elapsed
);

    localparam int PRE_W = (CLKS_PER_SEC > 1) ? $clog2(CLKS_PER_SEC) : 1;

    logic [PRE_W-1:0] prescaler;
    logic             sec_tick;

    assign sec_tick = (prescaler == PRE_W'(CLKS_PER_SEC - 1));

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prescaler <= '0;
            elapsed   <= '0;
        end
        else if (clear)
        begin
            prescaler <= '0;
            elapsed   <= '0;
        end
        else if (run)
        begin
            if (sec_tick)
            begin
                prescaler <= '0;
                if (elapsed != '1)
                    elapsed <= elapsed + 1'b1;  // hold at max
            end
            else
            begin
                prescaler <= prescaler + 1'b1;
            end
        end
    end

    // only a clear may move the count backwards
    a_no_decrease: assert property (@(posedge MCLK) disable iff (!rst_n)
        !clear |=> elapsed >= $past(elapsed));

endmodule

//--- src/sensor_pkg.sv
package sensor_pkg;

    // raw TC77 word as captured: sign, 12 magnitude bits, complete flag
    //   [13]    sign
    //   [12:1]  magnitude, 1/16 degC per lsb
    //   [0]     conversion complete
    typedef logic [13:0] tc77_word_t;

    // two's complement temperature in 1/16 degC
    typedef logic signed [12:0] temp_t;

    localparam int COMPLETE_BIT = 0;  // set once the first conversion is done

    // about 27 degC, above this the host boots without waiting
    localparam temp_t RELEASE_TEMP = 13'sh1AF;

    // 38 degC fan threshold, strictly above turns the fan on
    localparam temp_t FAN_TEMP = 13'sh260;

endpackage

//--- src/startup_ctrl.sv
`timescale 1ns/1ps

module startup_ctrl #(
    parameter int CHECK_PERIOD_S = 20
) (
    input  logic                    MCLK,
    input  logic                    rst_n,
    input  logic                    en_sync,
    input  timing_pkg::delay_mode_t delay_mode,
    input  logic                    fan_enable,
    input  logic                    force_pulse,
    output logic                    timer_clear,
    output logic                    timer_run,
    input  timing_pkg::seconds_t    elapsed,
    output logic                    temp_load,
    input  logic                    temp_done,
    input  sensor_pkg::tc77_word_t  temp_word,
    output logic                    hold_boot,
    output logic                    delaying,
    output logic                    fan_on
);

    timing_pkg::ctrl_state_t state;
    timing_pkg::delay_fx_t   delay_fx;   // 8 fraction bits
    timing_pkg::delay_fx_t   product;    // 12 fraction bits
    timing_pkg::seconds_t    delay_sec;
    sensor_pkg::temp_t       temp;
    logic                    neg_retry;  // a negative reading gets one more read
    logic                    wait_over;

    assign temp      = temp_word[13:1];
    assign delay_sec = delay_fx[23:8];  // fraction dropped
    assign wait_over = force_pulse || (elapsed >= delay_sec);

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= timing_pkg::ST_RESET;
            hold_boot   <= 1'b1;
            delaying    <= 1'b0;
            fan_on      <= 1'b0;
            timer_clear <= 1'b0;
            timer_run   <= 1'b0;
            temp_load   <= 1'b0;
            neg_retry   <= 1'b0;
        end
        else
        begin
            timer_clear <= 1'b0;
            temp_load   <= 1'b0;
            if (!en_sync)
            begin
                state     <= timing_pkg::ST_RESET;
                hold_boot <= 1'b1;
                delaying  <= 1'b0;
                fan_on    <= 1'b0;
                timer_run <= 1'b0;
            end
            else
            begin
                case (state)
                    timing_pkg::ST_RESET:
                    begin
                        timer_clear <= 1'b1;
                        neg_retry   <= 1'b0;
                        state       <= timing_pkg::ST_SELECT;
                    end
                    timing_pkg::ST_SELECT:
                    begin
                        timer_run <= 1'b1;
                        if (delay_mode == timing_pkg::MODE_MEASURED)
                            state <= timing_pkg::ST_MEAS_SEC;
                        else
                        begin
                            delaying <= 1'b1;
                            state    <= timing_pkg::ST_FIXED_WAIT;
                        end
                    end
                    timing_pkg::ST_FIXED_WAIT:
                        if (wait_over)
                            state <= timing_pkg::ST_RELEASE;
                    timing_pkg::ST_MEAS_SEC:
                    begin
                        if (force_pulse)
                            state <= timing_pkg::ST_RELEASE;
                        else if (elapsed != '0)
                        begin
                            temp_load   <= 1'b1;
                            timer_clear <= 1'b1;  // next try one second after this load
                            state       <= timing_pkg::ST_MEAS_READ;
                        end
                    end
                    timing_pkg::ST_MEAS_READ:
                    begin
                        if (force_pulse)
                            state <= timing_pkg::ST_RELEASE;
                        else if (temp_done)
                        begin
                            if (!temp_word[sensor_pkg::COMPLETE_BIT])
                                state <= timing_pkg::ST_MEAS_SEC;
                            else if (temp < 13'sd0 && !neg_retry)
                            begin
                                neg_retry <= 1'b1;
                                state     <= timing_pkg::ST_MEAS_SEC;
                            end
                            else if (temp > sensor_pkg::RELEASE_TEMP)
                                state <= timing_pkg::ST_RELEASE;  // warm enough already
                            else
                            begin
                                timer_clear <= 1'b1;
                                timer_run   <= 1'b0;
                                state       <= timing_pkg::ST_MEAS_MUL;
                            end
                        end
                    end
                    timing_pkg::ST_MEAS_MUL:
                        state <= timing_pkg::ST_MEAS_ADD;
                    timing_pkg::ST_MEAS_ADD:
                    begin
                        delaying  <= 1'b1;
                        timer_run <= 1'b1;
                        state     <= timing_pkg::ST_MEAS_WAIT;
                    end
                    timing_pkg::ST_MEAS_WAIT:
                        if (wait_over)
                            state <= timing_pkg::ST_RELEASE;
                    timing_pkg::ST_RELEASE:
                    begin
                        hold_boot   <= 1'b0;
                        delaying    <= 1'b0;
                        timer_run   <= 1'b0;
                        timer_clear <= 1'b1;  // start of the first fan period
                        state       <= timing_pkg::ST_FAN_IDLE;
                    end
                    timing_pkg::ST_FAN_IDLE:
                        if (fan_enable)
                        begin
                            timer_run <= 1'b1;
                            state     <= timing_pkg::ST_FAN_WAIT;
                        end
                    timing_pkg::ST_FAN_WAIT:
                        if (elapsed > timing_pkg::seconds_t'(CHECK_PERIOD_S))
                        begin
                            temp_load   <= 1'b1;
                            timer_clear <= 1'b1;
                            state       <= timing_pkg::ST_FAN_READ;
                        end
                    timing_pkg::ST_FAN_READ:
                        if (temp_done)
                        begin
                            fan_on <= (temp > sensor_pkg::FAN_TEMP);  // signed so cold never runs
                            state  <= timing_pkg::ST_FAN_WAIT;
                        end
                    default:
                        state <= timing_pkg::ST_RESET;
                endcase
            end
        end
    end

    // delay arithmetic in one multiply and one add stage
    always_ff @(posedge MCLK)
    begin
        if (state == timing_pkg::ST_SELECT)
        begin
            case (delay_mode)
                timing_pkg::MODE_SHORT: delay_fx <= timing_pkg::FIXED_DELAY_2;
                timing_pkg::MODE_MID:   delay_fx <= timing_pkg::FIXED_DELAY_80;
                timing_pkg::MODE_LONG:  delay_fx <= timing_pkg::FIXED_DELAY_260;
                default:                delay_fx <= '0;  // set later from the reading
            endcase
        end
        else if (state == timing_pkg::ST_MEAS_ADD)
            delay_fx <= (product >>> 4) + timing_pkg::DELAY_OFFSET;
        if (state == timing_pkg::ST_MEAS_MUL)
            product <= timing_pkg::delay_fx_t'(temp)
                       * timing_pkg::delay_fx_t'(timing_pkg::DELAY_SLOPE);
    end

    a_fan_after_boot: assert property (@(posedge MCLK) disable iff (!rst_n)
        fan_on |-> !hold_boot);

endmodule

//--- src/switch_regs.sv
`timescale 1ns/1ps

module switch_regs (
    input  logic                    MCLK,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic [2:0]              setting,     // fan, delay1, delay0
    input  logic                    force_start,
    output logic                    en_sync,
    output timing_pkg::delay_mode_t delay_mode,
    output logic                    fan_enable,
    output logic                    force_pulse
);

    logic [4:0] sync_meta;
    logic [4:0] sync_q;   // {force, setting, en}
    logic       en_d;
    logic       force_d;

    assign en_sync     = sync_q[0];
    assign force_pulse = sync_q[4] && !force_d;

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_meta  <= '0;
            sync_q     <= '0;
            en_d       <= 1'b0;
            force_d    <= 1'b0;
            delay_mode <= timing_pkg::MODE_SHORT;
            fan_enable <= 1'b0;
        end
        else
        begin
            sync_meta <= {force_start, setting, en};
            sync_q    <= sync_meta;
            en_d      <= sync_q[0];
            force_d   <= sync_q[4];
            if (sync_q[0] && !en_d)  // first enabled cycle
            begin
                delay_mode <= sync_q[2:1];
                fan_enable <= sync_q[3];
            end
        end
    end

endmodule

//--- src/tc77_reader.sv
`timescale 1ns/1ps

module tc77_reader #(
    parameter int SCK_DIV = 25
) (
    input  logic                   MCLK,
    input  logic                   rst_n,
    input  logic                   load,
    output logic                   done,
    output sensor_pkg::tc77_word_t temp_word,
    output logic                   sensor_cs,
    output logic                   sensor_sck,
    input  logic                   sensor_sio
);

    localparam int DIV_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

    logic                   busy;
    logic [DIV_W-1:0]       div_cnt;
    logic [5:0]             edge_cnt;   // sck edges in this frame, 32 per word
    logic [1:0]             tail;
    logic                   frame_end;
    logic                   sck_toggle;
    logic                   sck_rise;
    sensor_pkg::tc77_word_t shift_reg;

    assign frame_end  = (edge_cnt == 6'd32);
    assign sck_toggle = busy && !frame_end && (div_cnt == DIV_W'(SCK_DIV - 1));
    assign sck_rise   = sck_toggle && !sensor_sck;

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy       <= 1'b0;
            done       <= 1'b0;
            sensor_cs  <= 1'b1;
            sensor_sck <= 1'b0;
            div_cnt    <= '0;
            edge_cnt   <= '0;
            tail       <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (load)  // a load while busy is dropped
                begin
                    busy      <= 1'b1;
                    sensor_cs <= 1'b0;
                    div_cnt   <= '0;
                    edge_cnt  <= '0;
                    tail      <= '0;
                end
            end
            else if (!frame_end)
            begin
                if (sck_toggle)
                begin
                    div_cnt    <= '0;
                    sensor_sck <= ~sensor_sck;
                    edge_cnt   <= edge_cnt + 1'b1;
                end
                else
                begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
            else
            begin
                tail <= tail + 1'b1;
                if (tail == 2'd0)
                    sensor_cs <= 1'b1;  // deselect after the 16th clock
                if (tail == 2'd2)
                begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end
            end
        end
    end

    // msb first, bits past the 14th are don't care
    always_ff @(posedge MCLK)
    begin
        if (sck_rise && edge_cnt[5:1] < 5'd14)
            shift_reg <= {shift_reg[12:0], sensor_sio};
        if (busy && frame_end && tail == 2'd2)
            temp_word <= shift_reg;
    end

    a_sck_idle: assert property (@(posedge MCLK) disable iff (!rst_n)
        sensor_cs |-> !sensor_sck);

endmodule

//--- src/timing_pkg.sv
package timing_pkg;

    typedef logic [15:0] seconds_t;            // whole seconds
    typedef logic signed [31:0] delay_fx_t;    // seconds, 8 fraction bits
    typedef logic [1:0] delay_mode_t;          // delay switch code

    localparam delay_mode_t MODE_SHORT    = 2'b00;
    localparam delay_mode_t MODE_MID      = 2'b01;
    localparam delay_mode_t MODE_LONG     = 2'b10;
    localparam delay_mode_t MODE_MEASURED = 2'b11;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_SELECT,
        ST_FIXED_WAIT,
        ST_MEAS_SEC,      // wait one second before a read
        ST_MEAS_READ,
        ST_MEAS_MUL,
        ST_MEAS_ADD,
        ST_MEAS_WAIT,
        ST_RELEASE,
        ST_FAN_IDLE,
        ST_FAN_WAIT,
        ST_FAN_READ
    } ctrl_state_t;

    localparam delay_fx_t FIXED_DELAY_2   = 32'sh0000_0200;
    localparam delay_fx_t FIXED_DELAY_80  = 32'sh0000_5000;
    localparam delay_fx_t FIXED_DELAY_260 = 32'sh0001_0400;

    // delay = 485 - 16.8 * T
    localparam delay_fx_t DELAY_OFFSET = 32'sh0001_E500;  // 485.0
    localparam logic signed [15:0] DELAY_SLOPE = -16'sd4301;  // -16.8 in 8.8

endpackage
